// ==== sources.f ====
source/lsu_pkg.sv
source/mem_stage.sv
source/data_ram.sv
source/writeback_regfile.sv
source/retire_counters.sv
source/mem_wb_top.sv
testbench/tb_mem_wb_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_mem_wb_top
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_mem_wb_top.sv ====
`timescale 1ns/1ps

module tb_mem_wb_top;

    import lsu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int SUB_OPS = 200;
    localparam int ALU_OPS = 64;
    localparam int MIX_OPS = 300;
    // Each load plus drain costs three cycles and register sweeps add a few more
    localparam int RUN_CYCLES = RESET_CYCLES + 4
                              + DMEM_WORDS * 4
                              + SUB_OPS * 4
                              + ALU_OPS * 3 + 32
                              + MIX_OPS + 2 + 32 + DMEM_WORDS * 3;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    logic                   clk;
    logic                   reset;
    word_t                  ex_mem_pc;
    word_t                  ex_mem_alu_result;
    word_t                  ex_mem_rs2_data;
    reg_addr_t              ex_mem_rd_addr;
    ctrl_t                  ex_mem_control_signals;
    logic                   ex_mem_valid;
    reg_addr_t              rs1_addr;
    reg_addr_t              rs2_addr;
    word_t                  rs1_data;
    word_t                  rs2_data;
    word_t                  mem_wb_pc;
    logic                   dmem_read;
    logic [COUNT_WIDTH-1:0] retired_count;
    logic [COUNT_WIDTH-1:0] load_count;
    logic [COUNT_WIDTH-1:0] store_count;

    // Reference model state
    logic [7:0] mem_model [DMEM_WORDS*4];
    word_t      reg_model [32];
    int         model_retired;
    int         model_loads;
    int         model_stores;

    logic [15:0] lfsr_state;
    word_t       last_pc;
    logic        last_valid;
    logic        last_read;
    int          errors;
    int          test_errors;
    int          pc_errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;

    mem_wb_top dut (
        .clk                    (clk),
        .reset                  (reset),
        .ex_mem_pc              (ex_mem_pc),
        .ex_mem_alu_result      (ex_mem_alu_result),
        .ex_mem_rs2_data        (ex_mem_rs2_data),
        .ex_mem_rd_addr         (ex_mem_rd_addr),
        .ex_mem_control_signals (ex_mem_control_signals),
        .ex_mem_valid           (ex_mem_valid),
        .rs1_addr               (rs1_addr),
        .rs2_addr               (rs2_addr),
        .rs1_data               (rs1_data),
        .rs2_data               (rs2_data),
        .mem_wb_pc              (mem_wb_pc),
        .dmem_read              (dmem_read),
        .retired_count          (retired_count),
        .load_count             (load_count),
        .store_count            (store_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic word_t rand_pc();
        return word_t'(rand_bits(30)) << 2;
    endfunction

    function automatic reg_addr_t nonzero_reg();
        reg_addr_t r;
        r = reg_addr_t'(rand_bits(5));
        if (r == 5'd0) begin
            r = 5'd1;
        end
        return r;
    endfunction

    // Random address inside the 1 KB memory aligned to the access width
    function automatic word_t aligned_addr(input logic [2:0] width);
        logic [9:0] a;
        a = 10'(rand_bits(10));
        if (width == MEM_HALF) begin
            a[0] = 1'b0;
        end else if (width != MEM_BYTE) begin
            a[1:0] = 2'b00;
        end
        return word_t'(a);
    endfunction

    function automatic ctrl_t make_ctrl(input logic reg_write, input logic read,
                                        input logic write, input logic [2:0] width,
                                        input logic uns);
        ctrl_t c;
        c = '0;
        c[CTRL_REG_WRITE] = reg_write;
        c[CTRL_MEM_READ] = read;
        c[CTRL_MEM_WRITE] = write;
        c[CTRL_MEM_WIDTH_LSB +: 3] = width;
        c[CTRL_MEM_UNSIGNED] = uns;
        return c;
    endfunction

    // Store data sits at its lane position in the data word
    function automatic void store_model(input word_t addr, input logic [2:0] width,
                                        input word_t data);
        int base;
        base = int'(addr[9:0]);
        if (width == MEM_BYTE) begin
            mem_model[base] = data[8*(base%4) +: 8];
        end else if (width == MEM_HALF) begin
            base = base & ~1;
            mem_model[base] = data[8*(base%4) +: 8];
            mem_model[base+1] = data[8*(base%4)+8 +: 8];
        end else begin
            base = base & ~3;
            for (int i = 0; i < 4; i++) begin
                mem_model[base+i] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic word_t expected_load(input word_t addr, input logic [2:0] width,
                                            input logic uns);
        int          base;
        logic [7:0]  b;
        logic [15:0] h;
        base = int'(addr[9:0]);
        b = mem_model[base];
        h = {mem_model[(base & ~1) + 1], mem_model[base & ~1]};
        if (width == MEM_BYTE) begin
            return uns ? {24'b0, b} : {{24{b[7]}}, b};
        end else if (width == MEM_HALF) begin
            return uns ? {16'b0, h} : {{16{h[15]}}, h};
        end
        base = base & ~3;
        return {mem_model[base+3], mem_model[base+2], mem_model[base+1], mem_model[base]};
    endfunction

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("error: time %0t %s expected %h actual %h", $time, name, expected, actual);
        errors++;
        test_errors++;
    endtask

    // Present one operation and update the model from the pipeline rules
    task automatic issue_op(input logic valid, input word_t pc, input word_t alu,
                            input word_t data, input reg_addr_t rd, input ctrl_t ctrl);
        logic [2:0] width;
        word_t      load_val;
        @(posedge clk);
        #1;
        // The previous operation has just entered MEM/WB
        if (last_valid && mem_wb_pc !== last_pc) begin
            report_mismatch("mem_wb_pc", last_pc, mem_wb_pc);
            pc_errors++;
        end
        // The read strobe still belongs to the operation presented last
        if (dmem_read !== last_read) begin
            report_mismatch("dmem_read", word_t'(last_read), word_t'(dmem_read));
        end
        ex_mem_valid = valid;
        ex_mem_pc = pc;
        ex_mem_alu_result = alu;
        ex_mem_rs2_data = data;
        ex_mem_rd_addr = rd;
        ex_mem_control_signals = ctrl;
        last_valid = valid;
        last_pc = pc;
        last_read = valid & ctrl[CTRL_MEM_READ];
        width = ctrl[CTRL_MEM_WIDTH_LSB +: 3];
        load_val = expected_load(alu, width, ctrl[CTRL_MEM_UNSIGNED]);
        if (valid) begin
            model_retired++;
            if (ctrl[CTRL_MEM_READ]) begin
                model_loads++;
            end
            if (ctrl[CTRL_MEM_WRITE]) begin
                model_stores++;
                store_model(alu, width, data);
            end
            if (ctrl[CTRL_REG_WRITE] && rd != 5'd0) begin
                reg_model[rd] = ctrl[CTRL_MEM_READ] ? load_val : alu;
            end
        end
    endtask

    task automatic drain_pipeline();
        repeat (2) issue_op(1'b0, '0, '0, '0, '0, '0);
    endtask

    task automatic check_reg(input reg_addr_t r);
        rs1_addr = r;
        rs2_addr = r;
        #1;
        if (rs1_data !== reg_model[r]) begin
            report_mismatch($sformatf("rs1_data[x%0d]", r), reg_model[r], rs1_data);
        end
        if (rs2_data !== reg_model[r]) begin
            report_mismatch($sformatf("rs2_data[x%0d]", r), reg_model[r], rs2_data);
        end
    endtask

    task automatic load_and_check(input logic [7:0] idx, input reg_addr_t r);
        issue_op(1'b1, rand_pc(), word_t'({idx, 2'b00}), '0, r,
                 make_ctrl(1'b1, 1'b1, 1'b0, MEM_WORD, 1'b0));
        drain_pipeline();
        check_reg(r);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        reg_addr_t  rd;
        word_t      addr;
        logic [2:0] width;
        logic [1:0] kind;
        logic       uns;
        reset = 1'b1;
        ex_mem_pc = '0;
        ex_mem_alu_result = '0;
        ex_mem_rs2_data = '0;
        ex_mem_rd_addr = '0;
        ex_mem_control_signals = '0;
        ex_mem_valid = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        lfsr_state = 16'd35819;
        last_pc = '0;
        last_valid = 1'b0;
        last_read = 1'b0;
        {errors, test_errors, pc_errors, tests_run, tests_failed, cycle_count} = '0;
        {model_retired, model_loads, model_stores} = '0;
        foreach (mem_model[i]) mem_model[i] = '0;
        foreach (reg_model[i]) reg_model[i] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        rs1_addr = 5'd1;
        rs2_addr = 5'd31;
        #1;
        if (rs1_data !== '0) report_mismatch("rs1_data", '0, rs1_data);
        if (rs2_data !== '0) report_mismatch("rs2_data", '0, rs2_data);
        if (mem_wb_pc !== '0) report_mismatch("mem_wb_pc", '0, mem_wb_pc);
        if (retired_count !== '0) report_mismatch("retired_count", '0, retired_count);
        if (load_count !== '0) report_mismatch("load_count", '0, load_count);
        if (store_count !== '0) report_mismatch("store_count", '0, store_count);
        finish_test("reset_state");

        for (int i = 0; i < DMEM_WORDS; i++) begin
            issue_op(1'b1, rand_pc(), word_t'(i) << 2, rand_bits(32), nonzero_reg(),
                     make_ctrl(1'b0, 1'b0, 1'b1, MEM_WORD, 1'b0));
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            load_and_check(8'(i), nonzero_reg());
        end
        finish_test("word_round_trip");

        // Store then load the same address back to back
        for (int i = 0; i < SUB_OPS; i++) begin
            width = rand_bits(1) ? MEM_HALF : MEM_BYTE;
            addr = aligned_addr(width);
            uns = 1'(rand_bits(1));
            rd = nonzero_reg();
            issue_op(1'b1, rand_pc(), addr, rand_bits(32), rd,
                     make_ctrl(1'b0, 1'b0, 1'b1, width, 1'b0));
            issue_op(1'b1, rand_pc(), addr, '0, rd, make_ctrl(1'b1, 1'b1, 1'b0, width, uns));
            drain_pipeline();
            check_reg(rd);
        end
        finish_test("sub_word_access");

        for (int i = 0; i < ALU_OPS; i++) begin
            rd = (i % 8 == 0) ? 5'd0 : reg_addr_t'(rand_bits(5));
            if (rand_bits(1) == 1) begin
                issue_op(1'b1, rand_pc(), aligned_addr(MEM_WORD), rand_bits(32), rd,
                         make_ctrl(1'b0, 1'b0, 1'b1, MEM_WORD, 1'b0));
            end else begin
                issue_op(1'b1, rand_pc(), rand_bits(32), '0, rd,
                         make_ctrl(1'b1, 1'b0, 1'b0, MEM_WORD, 1'b0));
            end
            drain_pipeline();
            check_reg(rd);
        end
        finish_test("alu_writeback_x0");

        for (int i = 0; i < MIX_OPS; i++) begin
            kind = 2'(rand_bits(2));
            // Width code 3 must behave as a word access
            width = 3'(rand_bits(2));
            addr = aligned_addr(width);
            uns = 1'(rand_bits(1));
            rd = reg_addr_t'(rand_bits(5));
            if (rand_bits(2) == 0) begin
                issue_op(1'b0, rand_pc(), addr, rand_bits(32), rd,
                         make_ctrl(1'(rand_bits(1)), 1'b0, 1'b0, width, uns));
            end else if (kind == 2'd0) begin
                issue_op(1'b1, rand_pc(), addr, '0, rd, make_ctrl(1'b1, 1'b1, 1'b0, width, uns));
            end else if (kind == 2'd1) begin
                issue_op(1'b1, rand_pc(), addr, rand_bits(32), rd,
                         make_ctrl(1'b0, 1'b0, 1'b1, width, 1'b0));
            end else begin
                issue_op(1'b1, rand_pc(), rand_bits(32), '0, rd,
                         make_ctrl(1'b1, 1'b0, 1'b0, width, 1'b0));
            end
        end
        drain_pipeline();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            check_reg(reg_addr_t'(r));
        end
        if (retired_count !== word_t'(model_retired)) begin
            report_mismatch("retired_count", word_t'(model_retired), retired_count);
        end
        if (load_count !== word_t'(model_loads)) begin
            report_mismatch("load_count", word_t'(model_loads), load_count);
        end
        if (store_count !== word_t'(model_stores)) begin
            report_mismatch("store_count", word_t'(model_stores), store_count);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            load_and_check(8'(i), 5'd1);
        end
        finish_test("bubbles_counters");

        test_errors = pc_errors;
        finish_test("pipeline_pc");

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== source/mem_wb_top.sv ====
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                            clk,
    input  logic                            reset,

    // EX/MEM register contents
    input  lsu_pkg::word_t                  ex_mem_pc,
    input  lsu_pkg::word_t                  ex_mem_alu_result,
    input  lsu_pkg::word_t                  ex_mem_rs2_data,
    input  lsu_pkg::reg_addr_t              ex_mem_rd_addr,
    input  lsu_pkg::ctrl_t                  ex_mem_control_signals,
    input  logic                            ex_mem_valid,

    // Register file read ports
    input  lsu_pkg::reg_addr_t              rs1_addr,
    input  lsu_pkg::reg_addr_t              rs2_addr,
    output lsu_pkg::word_t                  rs1_data,
    output lsu_pkg::word_t                  rs2_data,

    // Observation
    output lsu_pkg::word_t                  mem_wb_pc,
    output logic                            dmem_read,
    output logic [lsu_pkg::COUNT_WIDTH-1:0] retired_count,
    output logic [lsu_pkg::COUNT_WIDTH-1:0] load_count,
    output logic [lsu_pkg::COUNT_WIDTH-1:0] store_count
);

    import lsu_pkg::*;

    // Data memory port
    word_t    dmem_addr;
    word_t    dmem_data_in;
    word_t    dmem_data_out;
    logic     dmem_write;
    byte_en_t dmem_byte_enable;

    // MEM/WB bundle
    word_t     mem_wb_alu_result;
    word_t     mem_wb_mem_data;
    reg_addr_t mem_wb_rd_addr;
    ctrl_t     mem_wb_control_signals;
    logic      mem_wb_valid;

    mem_stage u_mem_stage (
        .clk                    (clk),
        .reset                  (reset),
        .ex_mem_pc              (ex_mem_pc),
        .ex_mem_alu_result      (ex_mem_alu_result),
        .ex_mem_rs2_data        (ex_mem_rs2_data),
        .ex_mem_rd_addr         (ex_mem_rd_addr),
        .ex_mem_control_signals (ex_mem_control_signals),
        .ex_mem_valid           (ex_mem_valid),
        .dmem_addr              (dmem_addr),
        .dmem_data_in           (dmem_data_in),
        .dmem_data_out          (dmem_data_out),
        .dmem_read              (dmem_read),
        .dmem_write             (dmem_write),
        .dmem_byte_enable       (dmem_byte_enable),
        .mem_wb_pc              (mem_wb_pc),
        .mem_wb_alu_result      (mem_wb_alu_result),
        .mem_wb_mem_data        (mem_wb_mem_data),
        .mem_wb_rd_addr         (mem_wb_rd_addr),
        .mem_wb_control_signals (mem_wb_control_signals),
        .mem_wb_valid           (mem_wb_valid)
    );

    data_ram u_data_ram (
        .clk         (clk),
        .addr        (dmem_addr),
        .write_data  (dmem_data_out),
        .write       (dmem_write),
        .byte_enable (dmem_byte_enable),
        .read_data   (dmem_data_in)
    );

    writeback_regfile u_regfile (
        .clk                    (clk),
        .reset                  (reset),
        .mem_wb_alu_result      (mem_wb_alu_result),
        .mem_wb_mem_data        (mem_wb_mem_data),
        .mem_wb_rd_addr         (mem_wb_rd_addr),
        .mem_wb_control_signals (mem_wb_control_signals),
        .mem_wb_valid           (mem_wb_valid),
        .rs1_addr               (rs1_addr),
        .rs2_addr               (rs2_addr),
        .rs1_data               (rs1_data),
        .rs2_data               (rs2_data)
    );

    retire_counters u_counters (
        .clk                    (clk),
        .reset                  (reset),
        .mem_wb_control_signals (mem_wb_control_signals),
        .mem_wb_valid           (mem_wb_valid),
        .retired_count          (retired_count),
        .load_count             (load_count),
        .store_count            (store_count)
    );

endmodule

// ==== source/retire_counters.sv ====
`timescale 1ns/1ps

module retire_counters (
    input  logic                            clk,
    input  logic                            reset,
    input  lsu_pkg::ctrl_t                  mem_wb_control_signals,
    input  logic                            mem_wb_valid,
    output logic [lsu_pkg::COUNT_WIDTH-1:0] retired_count,
    output logic [lsu_pkg::COUNT_WIDTH-1:0] load_count,
    output logic [lsu_pkg::COUNT_WIDTH-1:0] store_count
);

    import lsu_pkg::*;

    logic is_load;
    logic is_store;

    // Only valid entries leaving WB count
    assign is_load  = mem_wb_valid & mem_wb_control_signals[CTRL_MEM_READ];
    assign is_store = mem_wb_valid & mem_wb_control_signals[CTRL_MEM_WRITE];

    // All three counters wrap silently
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retired_count <= '0;
            load_count    <= '0;
            store_count   <= '0;
        end else begin
            if (mem_wb_valid) begin
                retired_count <= retired_count + 1'b1;
            end
            if (is_load) begin
                load_count <= load_count + 1'b1;
            end
            if (is_store) begin
                store_count <= store_count + 1'b1;
            end
        end
    end

endmodule

// ==== source/writeback_regfile.sv ====
`timescale 1ns/1ps

module writeback_regfile (
    input  logic               clk,
    input  logic               reset,
    input  lsu_pkg::word_t     mem_wb_alu_result,
    input  lsu_pkg::word_t     mem_wb_mem_data,
    input  lsu_pkg::reg_addr_t mem_wb_rd_addr,
    input  lsu_pkg::ctrl_t     mem_wb_control_signals,
    input  logic               mem_wb_valid,
    input  lsu_pkg::reg_addr_t rs1_addr,
    input  lsu_pkg::reg_addr_t rs2_addr,
    output lsu_pkg::word_t     rs1_data,
    output lsu_pkg::word_t     rs2_data
);

    import lsu_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    word_t regs [NUM_REGS];
    word_t wb_data;
    logic  wb_enable;

    // Loaded data wins over the ALU result for loads
    assign wb_data = mem_wb_control_signals[CTRL_MEM_READ] ? mem_wb_mem_data
                                                           : mem_wb_alu_result;

    // x0 is never written
    assign wb_enable = mem_wb_valid
                     & mem_wb_control_signals[CTRL_REG_WRITE]
                     & (mem_wb_rd_addr != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable) begin
            regs[mem_wb_rd_addr] <= wb_data;
        end
    end

    // Asynchronous read ports
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  lsu_pkg::word_t    addr,
    input  lsu_pkg::word_t    write_data,
    input  logic              write,
    input  lsu_pkg::byte_en_t byte_enable,
    output lsu_pkg::word_t    read_data
);

    import lsu_pkg::*;

    word_t mem [DMEM_WORDS];

    logic [DMEM_INDEX_BITS-1:0] word_index;

    // Word index from address bits 9:2, upper bits wrap
    assign word_index = addr[DMEM_INDEX_BITS+1:2];

    // Per-lane write on the rising edge
    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (byte_enable[lane]) begin
                    mem[word_index][lane*8 +: 8] <= write_data[lane*8 +: 8];
                end
            end
        end
    end

    // Continuous read, so a load sees its word in the same cycle
    assign read_data = mem[word_index];

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk,
    input  logic                 reset,

    // EX/MEM register contents
    input  lsu_pkg::word_t       ex_mem_pc,
    input  lsu_pkg::word_t       ex_mem_alu_result,
    input  lsu_pkg::word_t       ex_mem_rs2_data,
    input  lsu_pkg::reg_addr_t   ex_mem_rd_addr,
    input  lsu_pkg::ctrl_t       ex_mem_control_signals,
    input  logic                 ex_mem_valid,

    // Single-cycle data memory port
    output lsu_pkg::word_t       dmem_addr,
    input  lsu_pkg::word_t       dmem_data_in,
    output lsu_pkg::word_t       dmem_data_out,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output lsu_pkg::byte_en_t    dmem_byte_enable,

    // MEM/WB register
    output lsu_pkg::word_t       mem_wb_pc,
    output lsu_pkg::word_t       mem_wb_alu_result,
    output lsu_pkg::word_t       mem_wb_mem_data,
    output lsu_pkg::reg_addr_t   mem_wb_rd_addr,
    output lsu_pkg::ctrl_t       mem_wb_control_signals,
    output logic                 mem_wb_valid
);

    import lsu_pkg::*;

    logic       mem_read_en;
    logic       mem_write_en;
    logic       mem_unsigned;
    mem_width_e mem_width;
    logic [1:0] byte_offset;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    word_t      load_data;

    // Unpack the control bundle
    assign mem_read_en  = ex_mem_control_signals[CTRL_MEM_READ];
    assign mem_write_en = ex_mem_control_signals[CTRL_MEM_WRITE];
    assign mem_unsigned = ex_mem_control_signals[CTRL_MEM_UNSIGNED];
    assign mem_width    = mem_width_e'(
        ex_mem_control_signals[CTRL_MEM_WIDTH_LSB +: MEM_WIDTH_BITS]);
    assign byte_offset  = ex_mem_alu_result[1:0];

    // Address and lane-aligned store data go straight out
    assign dmem_addr     = ex_mem_alu_result;
    assign dmem_data_out = ex_mem_rs2_data;
    assign dmem_read     = mem_read_en;
    // A bubble must never disturb memory
    assign dmem_write    = mem_write_en & ex_mem_valid;

    // Lane enables from access width and low address bits
    always_comb begin
        case (mem_width)
            MEM_BYTE: dmem_byte_enable = byte_en_t'(4'b0001 << byte_offset);
            MEM_HALF: dmem_byte_enable = byte_offset[1] ? 4'b1100 : 4'b0011;
            default:  dmem_byte_enable = 4'b1111;
        endcase
    end

    // Pick the addressed lane out of the returned word
    always_comb begin
        case (byte_offset)
            2'b00:   load_byte = dmem_data_in[7:0];
            2'b01:   load_byte = dmem_data_in[15:8];
            2'b10:   load_byte = dmem_data_in[23:16];
            default: load_byte = dmem_data_in[31:24];
        endcase
        load_half = byte_offset[1] ? dmem_data_in[31:16] : dmem_data_in[15:0];
    end

    // Loaded lane is zero or sign extended and non-loads return zero
    always_comb begin
        if (!mem_read_en) begin
            load_data = '0;
        end else begin
            case (mem_width)
                MEM_BYTE: begin
                    if (mem_unsigned) begin
                        load_data = {24'b0, load_byte};
                    end else begin
                        load_data = {{24{load_byte[7]}}, load_byte};
                    end
                end
                MEM_HALF: begin
                    if (mem_unsigned) begin
                        load_data = {16'b0, load_half};
                    end else begin
                        load_data = {{16{load_half[15]}}, load_half};
                    end
                end
                default:  load_data = dmem_data_in;
            endcase
        end
    end

    // MEM/WB pipeline register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb_pc              <= '0;
            mem_wb_alu_result      <= '0;
            mem_wb_mem_data        <= '0;
            mem_wb_rd_addr         <= '0;
            mem_wb_control_signals <= '0;
            mem_wb_valid           <= 1'b0;
        end else begin
            mem_wb_pc              <= ex_mem_pc;
            mem_wb_alu_result      <= ex_mem_alu_result;
            mem_wb_mem_data        <= load_data;
            mem_wb_rd_addr         <= ex_mem_rd_addr;
            mem_wb_control_signals <= ex_mem_control_signals;
            mem_wb_valid           <= ex_mem_valid;
        end
    end

endmodule

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    // Data path widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int BYTE_LANES = XLEN / 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // Control bundle carried from EX/MEM into MEM/WB
    localparam int CONTROL_SIGNALS_WIDTH = 7;

    typedef logic [CONTROL_SIGNALS_WIDTH-1:0] ctrl_t;

    // Bit positions inside ctrl_t
    localparam int CTRL_REG_WRITE = 0;
    localparam int CTRL_MEM_READ = 1;
    localparam int CTRL_MEM_WRITE = 2;
    localparam int CTRL_MEM_WIDTH_LSB = 3;
    localparam int CTRL_MEM_UNSIGNED = 6;

    // Width field is three bits wide, codes above MEM_WORD behave as word
    localparam int MEM_WIDTH_BITS = 3;

    typedef enum logic [MEM_WIDTH_BITS-1:0] {
        MEM_BYTE = 3'd0,
        MEM_HALF = 3'd1,
        MEM_WORD = 3'd2
    } mem_width_e;

    // Data memory geometry, 256 words = 1 KB
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_INDEX_BITS = 8;

    // Retirement statistics
    localparam int COUNT_WIDTH = 32;

endpackage
